//--- src/dec_arf_pkg.sv
package dec_arf_pkg;

   // ******************************
   // register file sizing
   // ******************************

   localparam int NUM_GPR = 32;            // x0..x31, x0 hardwired zero

   typedef logic [4:0]  reg_addr_t;        // gpr index
   typedef logic [31:0] xlen_t;            // gpr data word
   typedef logic [31:1] pc_t;              // halfword aligned pc, bit 0 implied

endpackage

//--- src/dec_trace_pkg.sv
package dec_trace_pkg;

   // ******************************
   // trace packet fields
   // ******************************

   // slot bits are {interrupt, i1, i0}
   typedef logic [2:0]  trace_slot_t;      // one bit per trace slot
   typedef logic [95:0] trace_insn_t;      // 3 x 32b insn words
   typedef logic [95:0] trace_addr_t;      // 3 x 32b addresses
   typedef logic [4:0]  ecause_t;          // exception cause code

endpackage

//--- src/gpr_rd_if.sv
`timescale 1ns/1ps

interface gpr_rd_if;
   import dec_arf_pkg::*;

   reg_addr_t rs1_addr;                    // rs1 index
   logic      rs1_en;                      // rs1 read enable
   reg_addr_t rs2_addr;                    // rs2 index
   logic      rs2_en;                      // rs2 read enable
   xlen_t     rs1_data;                    // rs1 read data, from arf
   xlen_t     rs2_data;                    // rs2 read data, from arf
   logic      rs1_pend;                    // rs1 waits on nb load
   logic      rs2_pend;                    // rs2 waits on nb load

   modport req (output rs1_addr, rs1_en, rs2_addr, rs2_en,
                input  rs1_data, rs2_data, rs1_pend, rs2_pend);   // decode side

   modport arf (input  rs1_addr, rs1_en, rs2_addr, rs2_en,
                output rs1_data, rs2_data);                        // register array

   modport sb  (input  rs1_addr, rs1_en, rs2_addr, rs2_en,
                output rs1_pend, rs2_pend);                        // load scoreboard

endinterface

//--- src/retire_if.sv
`timescale 1ns/1ps

interface retire_if;
   import dec_arf_pkg::*;
   import dec_trace_pkg::*;

   logic    i0_valid;                      // slot 0 retires
   logic    i1_valid;                      // slot 1 retires
   logic    i0_exc;                        // slot 0 took exception
   logic    i1_exc;                        // slot 1 took exception
   logic    int_valid;                     // interrupt taken
   pc_t     i0_pc;                         // slot 0 pc
   pc_t     i1_pc;                         // slot 1 pc
   xlen_t   i0_insn;                       // slot 0 insn word
   xlen_t   i1_insn;                       // slot 1 insn word
   ecause_t ecause;                        // shared exception cause
   xlen_t   tval;                          // shared trap value

   // trace stage only reads
   modport trc (input i0_valid, i1_valid, i0_exc, i1_exc, int_valid,
                      i0_pc, i1_pc, i0_insn, i1_insn, ecause, tval);

endinterface

//--- src/dec_gpr_ctl.sv
`timescale 1ns/1ps

module dec_gpr_ctl (
   input  logic                  clk,
   gpr_rd_if.arf                 rd_i0,        // slot 0 reads
   gpr_rd_if.arf                 rd_i1,        // slot 1 reads
   input  logic                  i0_wen,       // slot 0 wb write
   input  logic                  i1_wen,       // slot 1 wb write
   input  logic                  nbl_wen,      // nb load return write
   input  dec_arf_pkg::reg_addr_t i0_waddr,
   input  dec_arf_pkg::reg_addr_t i1_waddr,
   input  dec_arf_pkg::reg_addr_t nbl_waddr,
   input  dec_arf_pkg::xlen_t     i0_wdata,
   input  dec_arf_pkg::xlen_t     i1_wdata,
   input  dec_arf_pkg::xlen_t     nbl_wdata
);
   import dec_arf_pkg::*;

   xlen_t              gpr_q [1:NUM_GPR-1];   // x1..x31, no x0 storage
   logic [NUM_GPR-1:1] sel_i1;                // per-reg grant, slot 1
   logic [NUM_GPR-1:1] sel_i0;                // per-reg grant, slot 0
   logic [NUM_GPR-1:1] sel_nbl;               // per-reg grant, load return

   // ******************************
   // write arbitration
   // ******************************

   // fixed priority i1 > i0 > nbl
   always_comb begin
      for (int i = 1; i < NUM_GPR; i++) begin
         sel_i1[i]  = i1_wen & (i1_waddr == reg_addr_t'(i));
         sel_i0[i]  = i0_wen & (i0_waddr == reg_addr_t'(i)) & ~sel_i1[i];
         sel_nbl[i] = nbl_wen & (nbl_waddr == reg_addr_t'(i))
                      & ~sel_i1[i] & ~sel_i0[i];   // lowest priority
      end
   end

   // array has no reset
   always_ff @(posedge clk) begin
      for (int i = 1; i < NUM_GPR; i++) begin
         if (sel_i1[i]) begin
            gpr_q[i] <= i1_wdata;
         end
         else if (sel_i0[i]) begin
            gpr_q[i] <= i0_wdata;
         end
         else if (sel_nbl[i]) begin
            gpr_q[i] <= nbl_wdata;
         end
      end
   end

   // ******************************
   // read muxes
   // ******************************

   function automatic xlen_t gpr_read(input reg_addr_t addr, input logic en);
      xlen_t data;
      data = '0;                              // x0 or disabled port
      if (en && (addr != '0)) begin
         data = gpr_q[addr];
      end
      return data;
   endfunction

   // no wb bypass, new value shows next cycle
   always_comb begin
      rd_i0.rs1_data = gpr_read(rd_i0.rs1_addr, rd_i0.rs1_en);
      rd_i0.rs2_data = gpr_read(rd_i0.rs2_addr, rd_i0.rs2_en);
      rd_i1.rs1_data = gpr_read(rd_i1.rs1_addr, rd_i1.rs1_en);
      rd_i1.rs2_data = gpr_read(rd_i1.rs2_addr, rd_i1.rs2_en);
   end

endmodule

//--- src/dec_nbload_ctl.sv
`timescale 1ns/1ps

module dec_nbload_ctl #(
   parameter int NBL_TAG_W = 2                      // load tag width, 1..4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   alloc_valid,      // nb load issued, dc3
   input  logic [NBL_TAG_W-1:0]   alloc_tag,
   input  dec_arf_pkg::reg_addr_t alloc_waddr,      // its destination
   input  logic                   inv_valid,        // load killed, dc5
   input  logic [NBL_TAG_W-1:0]   inv_tag,
   input  logic                   data_valid,       // load data back
   input  logic                   data_error,       // bus error on return
   input  logic [NBL_TAG_W-1:0]   data_tag,
   input  dec_arf_pkg::xlen_t     data,
   gpr_rd_if.sb                   rd_i0,            // slot 0 pending flags
   gpr_rd_if.sb                   rd_i1,            // slot 1 pending flags
   output logic                   nbl_wen,          // write request to arf
   output dec_arf_pkg::reg_addr_t nbl_waddr,
   output dec_arf_pkg::xlen_t     nbl_wdata
);
   import dec_arf_pkg::*;

   localparam int NBL_DEPTH = 1 << NBL_TAG_W;       // one entry per tag

   logic [NBL_DEPTH-1:0] vld_q;                     // entry outstanding
   reg_addr_t            waddr_q [NBL_DEPTH];       // entry destination
   logic [NBL_DEPTH-1:0] set;                       // allocate this cycle
   logic [NBL_DEPTH-1:0] clr;                       // free this cycle
   logic                 alloc_en;                  // x0 loads are not tracked

   assign alloc_en = alloc_valid & (alloc_waddr != '0);

   // ******************************
   // tag table
   // ******************************

   always_comb begin
      for (int t = 0; t < NBL_DEPTH; t++) begin
         set[t] = alloc_en & (alloc_tag == NBL_TAG_W'(t));
         clr[t] = (inv_valid & (inv_tag == NBL_TAG_W'(t)))
                | (data_valid & (data_tag == NBL_TAG_W'(t)));   // good or bad return
      end
   end

   // a new alloc wins over a free, tag may be reused at once
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
      end
      else begin
         vld_q <= (vld_q & ~clr) | set;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc_en) begin
         waddr_q[alloc_tag] <= alloc_waddr;          // payload, no reset
      end
   end

   // return uses table as it stands before the edge
   assign nbl_wen   = data_valid & vld_q[data_tag] & ~data_error;
   assign nbl_waddr = waddr_q[data_tag];
   assign nbl_wdata = data;

   // ******************************
   // pending scoreboard
   // ******************************

   function automatic logic is_pend(input reg_addr_t addr, input logic en);
      logic hit;
      hit = 1'b0;
      for (int t = 0; t < NBL_DEPTH; t++) begin
         hit |= vld_q[t] & (waddr_q[t] == addr);    // cam compare
      end
      return en & hit;
   endfunction

   always_comb begin
      rd_i0.rs1_pend = is_pend(rd_i0.rs1_addr, rd_i0.rs1_en);
      rd_i0.rs2_pend = is_pend(rd_i0.rs2_addr, rd_i0.rs2_en);
      rd_i1.rs1_pend = is_pend(rd_i1.rs1_addr, rd_i1.rs1_en);
      rd_i1.rs2_pend = is_pend(rd_i1.rs2_addr, rd_i1.rs2_en);
   end

endmodule

//--- src/dec_trace_ctl.sv
`timescale 1ns/1ps

module dec_trace_ctl (
   input  logic                       clk,
   input  logic                       rst_n,
   retire_if.trc                      ret,              // wb retire info
   output dec_trace_pkg::trace_insn_t trace_insn,
   output dec_trace_pkg::trace_addr_t trace_addr,
   output dec_trace_pkg::trace_slot_t trace_valid,
   output dec_trace_pkg::trace_slot_t trace_exception,
   output dec_trace_pkg::trace_slot_t trace_interrupt,
   output dec_trace_pkg::ecause_t     trace_ecause,
   output dec_arf_pkg::xlen_t         trace_tval
);
   import dec_arf_pkg::*;
   import dec_trace_pkg::*;

   logic    i0_valid_wb1;                  // control, reset
   logic    i1_valid_wb1;
   logic    i0_exc_wb1;
   logic    i1_exc_wb1;
   logic    int_valid_wb1;
   pc_t     i0_pc_wb1;                     // payload, no reset
   pc_t     i1_pc_wb1;
   xlen_t   i0_insn_wb1;
   xlen_t   i1_insn_wb1;
   ecause_t ecause_wb1;
   xlen_t   tval_wb1;

   // ******************************
   // wb -> wb1
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         i0_valid_wb1  <= 1'b0;
         i1_valid_wb1  <= 1'b0;
         i0_exc_wb1    <= 1'b0;
         i1_exc_wb1    <= 1'b0;
         int_valid_wb1 <= 1'b0;
      end
      else begin
         i0_valid_wb1  <= ret.i0_valid;
         i1_valid_wb1  <= ret.i1_valid;
         i0_exc_wb1    <= ret.i0_exc;
         i1_exc_wb1    <= ret.i1_exc;
         int_valid_wb1 <= ret.int_valid;
      end
   end

   always_ff @(posedge clk) begin
      i0_pc_wb1   <= ret.i0_pc;
      i1_pc_wb1   <= ret.i1_pc;
      i0_insn_wb1 <= ret.i0_insn;
      i1_insn_wb1 <= ret.i1_insn;
      ecause_wb1  <= ret.ecause;
      tval_wb1    <= ret.tval;
   end

   // packet, top slot is interrupt only
   assign trace_insn      = {32'b0, i1_insn_wb1, i0_insn_wb1};
   assign trace_addr      = {32'b0, i1_pc_wb1, 1'b0, i0_pc_wb1, 1'b0};
   assign trace_valid     = {int_valid_wb1,
                             i1_valid_wb1 | i1_exc_wb1,     // exc still traced
                             i0_valid_wb1 | i0_exc_wb1};
   assign trace_exception = {int_valid_wb1, i1_exc_wb1, i0_exc_wb1};
   assign trace_interrupt = {int_valid_wb1, 2'b0};
   assign trace_ecause    = ecause_wb1;         // shared by all slots
   assign trace_tval      = tval_wb1;

endmodule

//--- src/dec_arf.sv
`timescale 1ns/1ps

module dec_arf #(
   parameter int NBL_TAG_W = 2                              // nb load tag width
) (
   input  logic                       clk,
   input  logic                       rst_n,
   // decode read requests
   input  dec_arf_pkg::reg_addr_t     i0_rs1_addr,
   input  logic                       i0_rs1_en,
   input  dec_arf_pkg::reg_addr_t     i0_rs2_addr,
   input  logic                       i0_rs2_en,
   input  dec_arf_pkg::reg_addr_t     i1_rs1_addr,
   input  logic                       i1_rs1_en,
   input  dec_arf_pkg::reg_addr_t     i1_rs2_addr,
   input  logic                       i1_rs2_en,
   output dec_arf_pkg::xlen_t         gpr_i0_rs1_d,         // gpr read data
   output dec_arf_pkg::xlen_t         gpr_i0_rs2_d,
   output dec_arf_pkg::xlen_t         gpr_i1_rs1_d,
   output dec_arf_pkg::xlen_t         gpr_i1_rs2_d,
   output logic                       i0_rs1_pend,          // waits on nb load
   output logic                       i0_rs2_pend,
   output logic                       i1_rs1_pend,
   output logic                       i1_rs2_pend,
   // writeback
   input  logic                       i0_wen_wb,
   input  dec_arf_pkg::reg_addr_t     i0_waddr_wb,
   input  dec_arf_pkg::xlen_t         i0_wdata_wb,
   input  logic                       i1_wen_wb,
   input  dec_arf_pkg::reg_addr_t     i1_waddr_wb,
   input  dec_arf_pkg::xlen_t         i1_wdata_wb,
   // lsu non-blocking loads
   input  logic                       lsu_nonblock_load_valid_dc3,
   input  logic [NBL_TAG_W-1:0]       lsu_nonblock_load_tag_dc3,
   input  dec_arf_pkg::reg_addr_t     lsu_nonblock_load_waddr_dc3,
   input  logic                       lsu_nonblock_load_inv_dc5,
   input  logic [NBL_TAG_W-1:0]       lsu_nonblock_load_inv_tag_dc5,
   input  logic                       lsu_nonblock_load_data_valid,
   input  logic                       lsu_nonblock_load_data_error,
   input  logic [NBL_TAG_W-1:0]       lsu_nonblock_load_data_tag,
   input  dec_arf_pkg::xlen_t         lsu_nonblock_load_data,
   // retire info
   input  logic                       i0_valid_wb,
   input  logic                       i1_valid_wb,
   input  logic                       i0_exc_wb,
   input  logic                       i1_exc_wb,
   input  logic                       int_valid_wb,
   input  dec_arf_pkg::pc_t           i0_pc_wb,
   input  dec_arf_pkg::pc_t           i1_pc_wb,
   input  dec_arf_pkg::xlen_t         i0_insn_wb,
   input  dec_arf_pkg::xlen_t         i1_insn_wb,
   input  dec_trace_pkg::ecause_t     ecause_wb,
   input  dec_arf_pkg::xlen_t         tval_wb,
   // trace port
   output dec_trace_pkg::trace_insn_t trace_rv_insn,
   output dec_trace_pkg::trace_addr_t trace_rv_addr,
   output dec_trace_pkg::trace_slot_t trace_rv_valid,
   output dec_trace_pkg::trace_slot_t trace_rv_exception,
   output dec_trace_pkg::trace_slot_t trace_rv_interrupt,
   output dec_trace_pkg::ecause_t     trace_rv_ecause,
   output dec_arf_pkg::xlen_t         trace_rv_tval
);
   import dec_arf_pkg::*;

   logic      nbl_wen;                  // load return write port
   reg_addr_t nbl_waddr;
   xlen_t     nbl_wdata;

   gpr_rd_if rd_i0 ();                  // slot 0 read bundle
   gpr_rd_if rd_i1 ();                  // slot 1 read bundle
   retire_if ret ();

   // ******************************
   // port hookup
   // ******************************

   assign rd_i0.rs1_addr = i0_rs1_addr;
   assign rd_i0.rs1_en   = i0_rs1_en;
   assign rd_i0.rs2_addr = i0_rs2_addr;
   assign rd_i0.rs2_en   = i0_rs2_en;
   assign rd_i1.rs1_addr = i1_rs1_addr;
   assign rd_i1.rs1_en   = i1_rs1_en;
   assign rd_i1.rs2_addr = i1_rs2_addr;
   assign rd_i1.rs2_en   = i1_rs2_en;

   assign gpr_i0_rs1_d = rd_i0.rs1_data;
   assign gpr_i0_rs2_d = rd_i0.rs2_data;
   assign gpr_i1_rs1_d = rd_i1.rs1_data;
   assign gpr_i1_rs2_d = rd_i1.rs2_data;
   assign i0_rs1_pend  = rd_i0.rs1_pend;
   assign i0_rs2_pend  = rd_i0.rs2_pend;
   assign i1_rs1_pend  = rd_i1.rs1_pend;
   assign i1_rs2_pend  = rd_i1.rs2_pend;

   assign ret.i0_valid  = i0_valid_wb;
   assign ret.i1_valid  = i1_valid_wb;
   assign ret.i0_exc    = i0_exc_wb;
   assign ret.i1_exc    = i1_exc_wb;
   assign ret.int_valid = int_valid_wb;
   assign ret.i0_pc     = i0_pc_wb;
   assign ret.i1_pc     = i1_pc_wb;
   assign ret.i0_insn   = i0_insn_wb;
   assign ret.i1_insn   = i1_insn_wb;
   assign ret.ecause    = ecause_wb;
   assign ret.tval      = tval_wb;

   // ******************************
   // instances
   // ******************************

   dec_gpr_ctl arf (
      .clk       (clk),
      .rd_i0     (rd_i0.arf),
      .rd_i1     (rd_i1.arf),
      .i0_wen    (i0_wen_wb),
      .i1_wen    (i1_wen_wb),
      .nbl_wen   (nbl_wen),
      .i0_waddr  (i0_waddr_wb),
      .i1_waddr  (i1_waddr_wb),
      .nbl_waddr (nbl_waddr),
      .i0_wdata  (i0_wdata_wb),
      .i1_wdata  (i1_wdata_wb),
      .nbl_wdata (nbl_wdata)
   );

   dec_nbload_ctl #(
      .NBL_TAG_W (NBL_TAG_W)
   ) nbload (
      .clk         (clk),
      .rst_n       (rst_n),
      .alloc_valid (lsu_nonblock_load_valid_dc3),
      .alloc_tag   (lsu_nonblock_load_tag_dc3),
      .alloc_waddr (lsu_nonblock_load_waddr_dc3),
      .inv_valid   (lsu_nonblock_load_inv_dc5),
      .inv_tag     (lsu_nonblock_load_inv_tag_dc5),
      .data_valid  (lsu_nonblock_load_data_valid),
      .data_error  (lsu_nonblock_load_data_error),
      .data_tag    (lsu_nonblock_load_data_tag),
      .data        (lsu_nonblock_load_data),
      .rd_i0       (rd_i0.sb),
      .rd_i1       (rd_i1.sb),
      .nbl_wen     (nbl_wen),
      .nbl_waddr   (nbl_waddr),
      .nbl_wdata   (nbl_wdata)
   );

   dec_trace_ctl trace (
      .clk             (clk),
      .rst_n           (rst_n),
      .ret             (ret.trc),
      .trace_insn      (trace_rv_insn),
      .trace_addr      (trace_rv_addr),
      .trace_valid     (trace_rv_valid),
      .trace_exception (trace_rv_exception),
      .trace_interrupt (trace_rv_interrupt),
      .trace_ecause    (trace_rv_ecause),
      .trace_tval      (trace_rv_tval)
   );

endmodule

//--- tests/dec_arf_chk.sv
`timescale 1ns/1ps

module dec_arf_chk (
   input logic                       clk,
   input logic                       rst_n,
   input dec_trace_pkg::trace_slot_t trace_rv_valid,
   input logic                       nbl_wen,        // internal load write port
   input dec_arf_pkg::reg_addr_t     nbl_waddr,
   input logic                       i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en,
   input logic                       i0_rs1_pend, i0_rs2_pend, i1_rs1_pend, i1_rs2_pend
);

   int n_fail = 0;                                   // assertion failures seen

   // valid regs clear on the reset edge
   trace_rst_a: assert property (@(posedge clk) !rst_n |=> trace_rv_valid == '0)
      else begin
         $error("trace valid set in the cycle after reset");
         n_fail++;
      end

   nbl_x0_a: assert property (@(posedge clk) disable iff (!rst_n)
                              nbl_wen |-> nbl_waddr != '0)
      else begin
         $error("load return writes x0");
         n_fail++;
      end

   pend_en_a: assert property (@(posedge clk) disable iff (!rst_n)
                               ((i0_rs1_pend & ~i0_rs1_en) | (i0_rs2_pend & ~i0_rs2_en)
                              | (i1_rs1_pend & ~i1_rs1_en) | (i1_rs2_pend & ~i1_rs2_en)) == 1'b0)
      else begin
         $error("pending flag high on a disabled read port");
         n_fail++;
      end

endmodule

bind dec_arf dec_arf_chk chk_i (.*);

//--- tests/dec_arf_monitor.sv
`timescale 1ns/1ps

module dec_arf_monitor #(
   parameter int NBL_TAG_W = 2
) (
   input logic                       clk, rst_n,
   input dec_arf_pkg::reg_addr_t     i0_rs1_addr, i0_rs2_addr, i1_rs1_addr, i1_rs2_addr,
   input logic                       i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en,
   input dec_arf_pkg::xlen_t         gpr_i0_rs1_d, gpr_i0_rs2_d, gpr_i1_rs1_d, gpr_i1_rs2_d,
   input logic                       i0_rs1_pend, i0_rs2_pend, i1_rs1_pend, i1_rs2_pend,
   input logic                       i0_wen_wb, i1_wen_wb,
   input dec_arf_pkg::reg_addr_t     i0_waddr_wb, i1_waddr_wb,
   input dec_arf_pkg::xlen_t         i0_wdata_wb, i1_wdata_wb,
   input logic                       lsu_nonblock_load_valid_dc3, lsu_nonblock_load_inv_dc5,
   input logic                       lsu_nonblock_load_data_valid,
   input logic                       lsu_nonblock_load_data_error,
   input logic [NBL_TAG_W-1:0]       lsu_nonblock_load_tag_dc3,
   input logic [NBL_TAG_W-1:0]       lsu_nonblock_load_inv_tag_dc5,
   input logic [NBL_TAG_W-1:0]       lsu_nonblock_load_data_tag,
   input dec_arf_pkg::reg_addr_t     lsu_nonblock_load_waddr_dc3,
   input dec_arf_pkg::xlen_t         lsu_nonblock_load_data,
   input logic                       i0_valid_wb, i1_valid_wb, i0_exc_wb, i1_exc_wb,
   input logic                       int_valid_wb,
   input dec_arf_pkg::pc_t           i0_pc_wb, i1_pc_wb,
   input dec_arf_pkg::xlen_t         i0_insn_wb, i1_insn_wb, tval_wb, trace_rv_tval,
   input dec_trace_pkg::ecause_t     ecause_wb, trace_rv_ecause,
   input dec_trace_pkg::trace_insn_t trace_rv_insn,
   input dec_trace_pkg::trace_addr_t trace_rv_addr,
   input dec_trace_pkg::trace_slot_t trace_rv_valid, trace_rv_exception, trace_rv_interrupt,
   output int                        err_cnt,
   output int                        chk_cnt
);
   import dec_arf_pkg::*;
   import dec_trace_pkg::*;

   localparam int DEPTH = 1 << NBL_TAG_W;

   xlen_t       gpr_m [NUM_GPR];                     // model regs, x until written
   logic        tag_vld [DEPTH];                     // model tag table
   reg_addr_t   tag_dst [DEPTH];
   trace_insn_t exp_insn;                            // packet expected this cycle
   trace_addr_t exp_addr;
   trace_slot_t exp_valid, exp_exc, exp_int;
   ecause_t     exp_ecause;
   xlen_t       exp_tval;
   int          last_err = 0;                        // counts at previous report
   int          last_chk = 0;

   initial begin
      err_cnt = 0;
      chk_cnt = 0;
      for (int i = 0; i < NUM_GPR; i++) begin
         gpr_m[i] = 'x;
      end
      gpr_m[0] = '0;                                 // x0 reads zero
   end

   function automatic xlen_t model_read(input reg_addr_t a, input logic en);
      return (en && a != '0) ? gpr_m[a] : '0;
   endfunction

   function automatic logic pend_lookup(input reg_addr_t a, input logic en);
      logic hit;
      hit = 1'b0;
      for (int t = 0; t < DEPTH; t++) begin
         hit |= tag_vld[t] && (tag_dst[t] == a);
      end
      return en & hit;
   endfunction

   task automatic cmp(input string name, input logic [95:0] exp, input logic [95:0] act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   task automatic report(input string name);
      $display("test %-8s done: %0d checks, %0d errors", name,
               chk_cnt - last_chk, err_cnt - last_err);
      last_err = err_cnt;
      last_chk = chk_cnt;
   endtask

   // ******************************
   // model update at the edge
   // ******************************

   always @(posedge clk) begin
      logic      ld_wen;
      reg_addr_t ld_dst;
      ld_dst = tag_dst[lsu_nonblock_load_data_tag];  // table before the edge
      ld_wen = lsu_nonblock_load_data_valid && tag_vld[lsu_nonblock_load_data_tag]
               && !lsu_nonblock_load_data_error;
      if (ld_wen && ld_dst != '0) gpr_m[ld_dst] = lsu_nonblock_load_data;   // lowest first
      if (i0_wen_wb && i0_waddr_wb != '0) gpr_m[i0_waddr_wb] = i0_wdata_wb;
      if (i1_wen_wb && i1_waddr_wb != '0) gpr_m[i1_waddr_wb] = i1_wdata_wb; // wins
      if (!rst_n) begin
         for (int t = 0; t < DEPTH; t++) begin
            tag_vld[t] = 1'b0;
         end
      end
      else begin
         if (lsu_nonblock_load_data_valid) tag_vld[lsu_nonblock_load_data_tag] = 1'b0;
         if (lsu_nonblock_load_inv_dc5) tag_vld[lsu_nonblock_load_inv_tag_dc5] = 1'b0;
         if (lsu_nonblock_load_valid_dc3 && lsu_nonblock_load_waddr_dc3 != '0) begin
            tag_vld[lsu_nonblock_load_tag_dc3] = 1'b1;
            tag_dst[lsu_nonblock_load_tag_dc3] = lsu_nonblock_load_waddr_dc3;
         end
      end
      exp_insn   = {32'b0, i1_insn_wb, i0_insn_wb};
      exp_addr   = {32'b0, i1_pc_wb, 1'b0, i0_pc_wb, 1'b0};  // pc bit 0 is zero
      exp_valid  = rst_n ? {int_valid_wb, i1_valid_wb | i1_exc_wb, i0_valid_wb | i0_exc_wb}
                         : '0;
      exp_exc    = rst_n ? {int_valid_wb, i1_exc_wb, i0_exc_wb} : '0;
      exp_int    = rst_n ? {int_valid_wb, 2'b0} : '0;
      exp_ecause = ecause_wb;
      exp_tval   = tval_wb;
   end

   // ******************************
   // compare mid cycle
   // ******************************

   always @(negedge clk) begin
      if (rst_n) begin
         cmp("gpr_i0_rs1_d", model_read(i0_rs1_addr, i0_rs1_en), gpr_i0_rs1_d);
         cmp("gpr_i0_rs2_d", model_read(i0_rs2_addr, i0_rs2_en), gpr_i0_rs2_d);
         cmp("gpr_i1_rs1_d", model_read(i1_rs1_addr, i1_rs1_en), gpr_i1_rs1_d);
         cmp("gpr_i1_rs2_d", model_read(i1_rs2_addr, i1_rs2_en), gpr_i1_rs2_d);
         cmp("i0_rs1_pend", pend_lookup(i0_rs1_addr, i0_rs1_en), i0_rs1_pend);
         cmp("i0_rs2_pend", pend_lookup(i0_rs2_addr, i0_rs2_en), i0_rs2_pend);
         cmp("i1_rs1_pend", pend_lookup(i1_rs1_addr, i1_rs1_en), i1_rs1_pend);
         cmp("i1_rs2_pend", pend_lookup(i1_rs2_addr, i1_rs2_en), i1_rs2_pend);
         cmp("trace_rv_insn", exp_insn, trace_rv_insn);
         cmp("trace_rv_addr", exp_addr, trace_rv_addr);
         cmp("trace_rv_valid", exp_valid, trace_rv_valid);
         cmp("trace_rv_exception", exp_exc, trace_rv_exception);
         cmp("trace_rv_interrupt", exp_int, trace_rv_interrupt);
         cmp("trace_rv_ecause", exp_ecause, trace_rv_ecause);
         cmp("trace_rv_tval", exp_tval, trace_rv_tval);
      end
   end

endmodule

//--- tests/tb_dec_arf.sv
`timescale 1ns/1ps

module tb_dec_arf;
   import dec_arf_pkg::*;
   import dec_trace_pkg::*;

   localparam int NBL_TAG_W = 2;
   localparam int N_FILL    = 31;                    // one write per reg
   localparam int N_RW      = 200;
   localparam int N_ARB     = 40;                    // 3 cycles each
   localparam int N_LOAD    = 200;
   localparam int N_FREE    = 200;
   localparam int N_TRACE   = 150;
   localparam int TIMEOUT_CYC = 3 * (N_FILL + N_RW + 3 * N_ARB + N_LOAD + N_FREE + N_TRACE) / 2;

   logic                   clk, rst_n;
   reg_addr_t              i0_rs1_addr, i0_rs2_addr, i1_rs1_addr, i1_rs2_addr;
   logic                   i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en;
   xlen_t                  gpr_i0_rs1_d, gpr_i0_rs2_d, gpr_i1_rs1_d, gpr_i1_rs2_d;
   logic                   i0_rs1_pend, i0_rs2_pend, i1_rs1_pend, i1_rs2_pend;
   logic                   i0_wen_wb, i1_wen_wb;
   reg_addr_t              i0_waddr_wb, i1_waddr_wb;
   xlen_t                  i0_wdata_wb, i1_wdata_wb;
   logic                   lsu_nonblock_load_valid_dc3, lsu_nonblock_load_inv_dc5;
   logic                   lsu_nonblock_load_data_valid, lsu_nonblock_load_data_error;
   logic [NBL_TAG_W-1:0]   lsu_nonblock_load_tag_dc3, lsu_nonblock_load_inv_tag_dc5;
   logic [NBL_TAG_W-1:0]   lsu_nonblock_load_data_tag;
   reg_addr_t              lsu_nonblock_load_waddr_dc3;
   xlen_t                  lsu_nonblock_load_data;
   logic                   i0_valid_wb, i1_valid_wb, i0_exc_wb, i1_exc_wb, int_valid_wb;
   pc_t                    i0_pc_wb, i1_pc_wb;
   xlen_t                  i0_insn_wb, i1_insn_wb, tval_wb, trace_rv_tval;
   ecause_t                ecause_wb, trace_rv_ecause;
   trace_insn_t            trace_rv_insn;
   trace_addr_t            trace_rv_addr;
   trace_slot_t            trace_rv_valid, trace_rv_exception, trace_rv_interrupt;
   int                     err_cnt, chk_cnt;         // from monitor
   int                     seed;
   int                     cyc = 0;

   dec_arf #(.NBL_TAG_W(NBL_TAG_W)) dut_i (.*);
   dec_arf_monitor #(.NBL_TAG_W(NBL_TAG_W)) mon_i (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;                             // 10 ns

   always @(posedge clk) begin
      cyc++;
      if (cyc > TIMEOUT_CYC) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("TB FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] rnd();
      return $random(seed);
   endfunction

   task automatic step();
      @(posedge clk);
      #1;                                            // drive after the edge
   endtask

   task automatic idle();
      {i0_rs1_addr, i0_rs2_addr, i1_rs1_addr, i1_rs2_addr} = '0;
      {i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en} = '0;
      {i0_wen_wb, i1_wen_wb, i0_waddr_wb, i1_waddr_wb, i0_wdata_wb, i1_wdata_wb} = '0;
      {lsu_nonblock_load_valid_dc3, lsu_nonblock_load_tag_dc3} = '0;
      {lsu_nonblock_load_waddr_dc3, lsu_nonblock_load_inv_dc5} = '0;
      {lsu_nonblock_load_inv_tag_dc5, lsu_nonblock_load_data_valid} = '0;
      {lsu_nonblock_load_data_error, lsu_nonblock_load_data_tag} = '0;
      lsu_nonblock_load_data = '0;
      {i0_valid_wb, i1_valid_wb, i0_exc_wb, i1_exc_wb, int_valid_wb} = '0;
      {i0_pc_wb, i1_pc_wb, i0_insn_wb, i1_insn_wb, ecause_wb, tval_wb} = '0;
   endtask

   task automatic rand_reads(input reg_addr_t mask);
      logic [31:0] r;
      r = rnd();
      i0_rs1_addr = r[4:0] & mask;                   // mask narrows to hot regs
      i0_rs2_addr = r[9:5] & mask;
      i1_rs1_addr = r[14:10] & mask;
      i1_rs2_addr = r[19:15] & mask;
      {i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en} = r[23:20] | r[27:24];   // mostly on
   endtask

   task automatic load_traffic(input int n, input logic frees);
      logic [31:0] r;
      for (int k = 0; k < n; k++) begin
         idle();
         rand_reads(5'h03);
         r = rnd();
         lsu_nonblock_load_valid_dc3   = r[0];
         lsu_nonblock_load_tag_dc3     = r[NBL_TAG_W+1:2];
         lsu_nonblock_load_waddr_dc3   = {3'b0, r[9:8]};     // x0 allocs nothing
         lsu_nonblock_load_data_valid  = r[10];
         lsu_nonblock_load_data_tag    = lsu_nonblock_load_tag_dc3 + NBL_TAG_W'(1);
         lsu_nonblock_load_data_error  = frees & r[11];
         lsu_nonblock_load_inv_dc5     = frees & r[12];
         lsu_nonblock_load_inv_tag_dc5 = lsu_nonblock_load_tag_dc3 + NBL_TAG_W'(2);
         lsu_nonblock_load_data        = rnd();
         step();
      end
   endtask

   // ******************************
   // test sequence
   // ******************************

   initial begin
      logic [31:0] r;
      reg_addr_t   a;
      int          n_err;
      seed  = 9645;
      rst_n = 1'b0;
      idle();
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;

      for (int k = 1; k < NUM_GPR; k++) begin        // first write of every reg
         idle();
         if (k[0]) {i0_wen_wb, i0_waddr_wb, i0_wdata_wb} = {1'b1, reg_addr_t'(k), rnd()};
         else      {i1_wen_wb, i1_waddr_wb, i1_wdata_wb} = {1'b1, reg_addr_t'(k), rnd()};
         step();
      end
      for (int k = 0; k < N_RW; k++) begin
         rand_reads(5'h1f);
         r = rnd();
         {i0_wen_wb, i1_wen_wb} = r[1:0];
         i0_waddr_wb = r[6:2];
         i1_waddr_wb = r[11:7];
         i0_wdata_wb = rnd();
         i1_wdata_wb = rnd();
         i0_rs1_addr = i0_waddr_wb;                  // same-cycle read sees old value
         step();
      end
      idle();
      step();
      mon_i.report("fill_rw");

      for (int k = 0; k < N_ARB; k++) begin
         idle();
         r = rnd();
         a = (r[4:0] == '0) ? 5'd1 : r[4:0];
         {lsu_nonblock_load_valid_dc3, lsu_nonblock_load_waddr_dc3} = {1'b1, a};
         lsu_nonblock_load_tag_dc3 = r[NBL_TAG_W+4:5];
         step();
         idle();                                     // three writers, one reg
         {lsu_nonblock_load_data_valid, lsu_nonblock_load_data} = {1'b1, rnd()};
         lsu_nonblock_load_data_tag = r[NBL_TAG_W+4:5];
         {i0_wen_wb, i0_waddr_wb, i0_wdata_wb} = {r[16], a, rnd()};
         {i1_wen_wb, i1_waddr_wb, i1_wdata_wb} = {r[17], a, rnd()};
         {i0_rs1_en, i0_rs1_addr} = {1'b1, a};
         step();
         idle();
         {i0_rs1_en, i0_rs1_addr, i1_rs2_en, i1_rs2_addr} = {1'b1, a, 1'b1, a};
         step();
      end
      mon_i.report("arb");

      load_traffic(N_LOAD, 1'b0);
      idle();
      step();
      mon_i.report("load");
      load_traffic(N_FREE, 1'b1);                    // inv and error returns
      idle();
      step();
      mon_i.report("free");

      for (int k = 0; k < N_TRACE; k++) begin
         idle();
         r = rnd();
         {int_valid_wb, i1_exc_wb, i0_exc_wb, i1_valid_wb, i0_valid_wb} = r[4:0];
         ecause_wb  = r[9:5];
         r = rnd();
         i0_pc_wb   = r[31:1];
         r = rnd();
         i1_pc_wb   = r[31:1];
         i0_insn_wb = rnd();
         i1_insn_wb = rnd();
         tval_wb    = rnd();
         step();
      end
      idle();
      step();
      step();
      mon_i.report("trace");

      n_err = err_cnt + dut_i.chk_i.n_fail;          // fold in assertion failures
      $display("total: %0d checks, %0d errors", chk_cnt, n_err);
      if (n_err == 0) begin
         $display("TB PASSED");
      end
      else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- dec_arf.f
src/dec_arf_pkg.sv
src/dec_trace_pkg.sv
src/gpr_rd_if.sv
src/retire_if.sv
src/dec_gpr_ctl.sv
src/dec_nbload_ctl.sv
src/dec_trace_ctl.sv
src/dec_arf.sv
tests/dec_arf_chk.sv
tests/dec_arf_monitor.sv
tests/tb_dec_arf.sv

//--- Bender.yml
package:
  name: dec_arf

sources:
  - src/dec_arf_pkg.sv
  - src/dec_trace_pkg.sv
  - src/gpr_rd_if.sv
  - src/retire_if.sv
  - src/dec_gpr_ctl.sv
  - src/dec_nbload_ctl.sv
  - src/dec_trace_ctl.sv
  - src/dec_arf.sv
  - target: test
    files:
      - tests/dec_arf_chk.sv
      - tests/dec_arf_monitor.sv
      - tests/tb_dec_arf.sv
